//--- sha256_core.f
+incdir+.
sha256_const_pkg.sv
sha256_types_pkg.sv
sha256_if.sv
sha256_ctrl.sv
msg_schedule.sv
round_datapath.sv
sha256_core.sv
tb_sha256_core.sv

//--- tb_sha256_model.svh
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH

// rotate right by n
function automatic word_t rotr(input word_t x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// one compression of a 512-bit block, word 0 in the top bits
function automatic logic [255:0] compress_block(input logic [255:0] init_flat,
	input logic [511:0] block);
	word_t       w [ROUNDS];
	word_t       v [8];
	word_t       s0;
	word_t       s1;
	word_t       chv;
	word_t       majv;
	word_t       t1;
	word_t       t2;
	hash_state_u init;
	hash_state_u res;

	init.flat = init_flat;

	// full schedule up front
	for (int t = 0; t < BLOCK_WORDS; t++)
		w[t] = block[511 - 32 * t -: 32];
	for (int t = BLOCK_WORDS; t < ROUNDS; t++) begin
		s0 = rotr(w[t - 15], 7) ^ rotr(w[t - 15], 18) ^ (w[t - 15] >> 3);
		s1 = rotr(w[t - 2], 17) ^ rotr(w[t - 2], 19) ^ (w[t - 2] >> 10);
		w[t] = s1 + w[t - 7] + s0 + w[t - 16];
	end

	// v[0] is a, v[7] is h
	for (int i = 0; i < 8; i++)
		v[i] = init.flat[255 - 32 * i -: 32];

	for (int t = 0; t < ROUNDS; t++) begin
		s1 = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
		chv = (v[4] & v[5]) ^ (~v[4] & v[6]);
		t1 = v[7] + s1 + chv + ROUND_K[t] + w[t];
		s0 = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
		majv = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
		t2 = s0 + majv;
		for (int i = 7; i > 0; i--)
			v[i] = v[i - 1];
		v[4] = v[4] + t1;
		v[0] = t1 + t2;
	end

	// feed-forward through the word view
	res.w.a = v[0] + init.w.a;
	res.w.b = v[1] + init.w.b;
	res.w.c = v[2] + init.w.c;
	res.w.d = v[3] + init.w.d;
	res.w.e = v[4] + init.w.e;
	res.w.f = v[5] + init.w.f;
	res.w.g = v[6] + init.w.g;
	res.w.h = v[7] + init.w.h;
	return res.flat;
endfunction

`endif

//--- tb_sha256_core.sv
`timescale 1ns/1ps

module tb_sha256_core;

	import sha256_const_pkg::*;
	import sha256_types_pkg::*;

	`include "tb_sha256_model.svh"

	localparam int NUM_BLOCKS = 26;
	localparam int CYCLE_LIMIT = NUM_BLOCKS * 90 + 50;
	localparam int DONE_DELAY = 66;

	localparam logic [255:0] IV = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
	// padded "abc"
	localparam logic [511:0] ABC_BLOCK = {32'h61626380, 448'h0, 32'h00000018};
	localparam logic [255:0] ABC_DIGEST = {32'hba7816bf, 32'h8f01cfea, 32'h414140de,
		32'h5dae2223, 32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad};

	logic         clk = 1'b0;
	logic         rst_n;
	logic         msg_valid;
	word_t        msg_word;
	logic [255:0] h_init;
	logic         rdy;
	logic         done;
	logic [255:0] digest;

	int           seed = 32'h92f9fc6c;
	int           cycle_cnt = 0;
	int           digest_errs = 0;
	int           timing_errs = 0;
	int           reset_errs = 0;
	int           seq_errs = 0;
	logic [255:0] exp_q [$];

	always #2 clk = ~clk;

	sha256_core sha256_core_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.msg_valid (msg_valid),
		.msg_word  (msg_word),
		.h_init    (h_init),
		.rdy       (rdy),
		.done      (done),
		.digest    (digest)
	);

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic random_block(output logic [511:0] blk);
		for (int i = 0; i < BLOCK_WORDS; i++)
			blk[32 * i +: 32] = $random(seed);
	endtask

	task automatic random_state(output logic [255:0] h);
		for (int i = 0; i < 8; i++)
			h[32 * i +: 32] = $random(seed);
	endtask

	task automatic timing_error(input string name, input logic got, input logic exp, input int n);
		timing_errs++;
		$display("Error: %s = %h, expected %h, %0d cycles after the last word", name, got, exp, n);
	endtask

	// sixteen words at consecutive falling edges
	task automatic drive_words(input logic [255:0] h, input logic [511:0] blk);
		@(negedge clk);
		while (!rdy)
			@(negedge clk);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			if (i > 0)
				@(negedge clk);
			msg_valid = 1'b1;
			msg_word = blk[511 - 32 * i -: 32];
			// h_init only counts with the first word
			h_init = (i == 0) ? h : ~h;
		end
	endtask

	// full block with rdy and done watched up to the done pulse
	task automatic send_block(input logic [255:0] h, input logic [511:0] blk, input bit junk);
		word_t junk_word;
		drive_words(h, blk);
		for (int n = 1; n <= DONE_DELAY; n++) begin
			@(negedge clk);
			if (n < DONE_DELAY) begin
				assert (rdy === 1'b0) else timing_error("rdy", rdy, 1'b0, n);
				assert (done === 1'b0) else timing_error("done", done, 1'b0, n);
			end else begin
				assert (done === 1'b1) else timing_error("done", done, 1'b1, n);
				assert (rdy === 1'b1) else timing_error("rdy", rdy, 1'b1, n);
			end
			if (junk && n < DONE_DELAY) begin
				// strobes while busy must be dropped
				junk_word = $random(seed);
				msg_valid = junk_word[0];
				msg_word = junk_word;
				h_init = ~h_init;
			end else begin
				msg_valid = 1'b0;
			end
		end
	endtask

	// block cut short by an asynchronous reset mid-run
	task automatic abort_by_reset(input logic [511:0] blk);
		drive_words(IV, blk);
		@(negedge clk);
		msg_valid = 1'b0;
		repeat (20) @(negedge clk);
		rst_n = 1'b0;
		#0.5;
		assert (rdy === 1'b1) else begin
			reset_errs++;
			$display("Error: rdy = %h, expected %h during reset", rdy, 1'b1);
		end
		assert (done === 1'b0) else begin
			reset_errs++;
			$display("Error: done = %h, expected %h during reset", done, 1'b0);
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// digest comparison
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic [255:0] expected;
		if (rst_n && done) begin
			assert (exp_q.size() > 0) else begin
				seq_errs++;
				$display("done pulsed with no block outstanding");
			end
			if (exp_q.size() > 0) begin
				expected = exp_q.pop_front();
				assert (digest === expected) else begin
					digest_errs++;
					$display("Error: digest = %h, expected %h", digest, expected);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [511:0] blk;
		logic [511:0] blk2;
		logic [255:0] h;
		logic [255:0] mid;

		rst_n = 1'b0;
		msg_valid = 1'b0;
		msg_word = '0;
		h_init = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// model against the published value
		assert (compress_block(IV, ABC_BLOCK) === ABC_DIGEST) else begin
			seq_errs++;
			$display("reference model does not reproduce the known abc digest");
		end

		exp_q.push_back(compress_block(IV, ABC_BLOCK));
		send_block(IV, ABC_BLOCK, 1'b0);

		repeat (20) begin
			random_state(h);
			random_block(blk);
			exp_q.push_back(compress_block(h, blk));
			send_block(h, blk, 1'b0);
		end

		// two-block message whose second h_init comes from the dut
		random_block(blk);
		random_block(blk2);
		mid = compress_block(IV, blk);
		exp_q.push_back(mid);
		send_block(IV, blk, 1'b0);
		exp_q.push_back(compress_block(mid, blk2));
		send_block(digest, blk2, 1'b0);

		random_state(h);
		random_block(blk);
		exp_q.push_back(compress_block(h, blk));
		send_block(h, blk, 1'b1);

		random_block(blk);
		abort_by_reset(blk);
		random_state(h);
		random_block(blk);
		exp_q.push_back(compress_block(h, blk));
		send_block(h, blk, 1'b0);

		repeat (2) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			seq_errs++;
			$display("%0d blocks never produced a digest", exp_q.size());
		end

		$display("errors: digest %0d, timing %0d, reset %0d, sequence %0d",
			digest_errs, timing_errs, reset_errs, seq_errs);
		if (digest_errs + timing_errs + reset_errs + seq_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- sha256_core.sv
`timescale 1ns/1ps

module sha256_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    msg_valid,
	input  sha256_const_pkg::word_t msg_word,
	input  logic [255:0]            h_init,
	output logic                    rdy,
	output logic                    done,
	output logic [255:0]            digest
);

	//////////////////////////////////////////////////////////////////////////////
	// internal buses
	//////////////////////////////////////////////////////////////////////////////

	sched_if sched_bus ();
	round_if round_bus ();

	// words go straight to the window, gated there by load
	assign sched_bus.msg_word = msg_word;

	//////////////////////////////////////////////////////////////////////////////
	// control and datapaths
	//////////////////////////////////////////////////////////////////////////////

	sha256_ctrl sha256_ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.msg_valid (msg_valid),
		.rdy       (rdy),
		.done      (done),
		.sched     (sched_bus),
		.rnd       (round_bus)
	);

	msg_schedule msg_schedule_i (
		.clk   (clk),
		.rst_n (rst_n),
		.sched (sched_bus)
	);

	round_datapath round_datapath_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.h_init (h_init),
		.w_t    (sched_bus.w_t),
		.rnd    (round_bus),
		.digest (digest)
	);

endmodule

//--- round_datapath.sv
`timescale 1ns/1ps

module round_datapath (
	input  logic                          clk,
	input  logic                          rst_n,
	input  sha256_types_pkg::hash_state_u h_init,
	input  sha256_const_pkg::word_t       w_t,
	round_if.datapath                     rnd,
	output sha256_types_pkg::hash_state_u digest
);

	import sha256_const_pkg::*;
	import sha256_types_pkg::*;

	hash_state_u work;
	hash_state_u init_q;
	hash_state_u rounded;
	hash_state_u feed_fwd;
	word_t       t1;
	word_t       t2;

	// Sigma0: ror 2, ror 13, ror 22
	function automatic word_t big_sigma0(input word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	// Sigma1: ror 6, ror 11, ror 25
	function automatic word_t big_sigma1(input word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	//////////////////////////////////////////////////////////////////////////////
	// round function
	//////////////////////////////////////////////////////////////////////////////

	assign t1 = work.w.h + big_sigma1(work.w.e) + ch(work.w.e, work.w.f, work.w.g)
		+ ROUND_K[rnd.round] + w_t;
	assign t2 = big_sigma0(work.w.a) + maj(work.w.a, work.w.b, work.w.c);

	always_comb begin
		rounded.w.a = t1 + t2;
		rounded.w.b = work.w.a;
		rounded.w.c = work.w.b;
		rounded.w.d = work.w.c;
		rounded.w.e = work.w.d + t1;
		rounded.w.f = work.w.e;
		rounded.w.g = work.w.f;
		rounded.w.h = work.w.g;
	end

	// word-wise feed-forward, no carry between words
	always_comb begin
		feed_fwd.w.a = work.w.a + init_q.w.a;
		feed_fwd.w.b = work.w.b + init_q.w.b;
		feed_fwd.w.c = work.w.c + init_q.w.c;
		feed_fwd.w.d = work.w.d + init_q.w.d;
		feed_fwd.w.e = work.w.e + init_q.w.e;
		feed_fwd.w.f = work.w.f + init_q.w.f;
		feed_fwd.w.g = work.w.g + init_q.w.g;
		feed_fwd.w.h = work.w.h + init_q.w.h;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			work <= '0;
			init_q <= '0;
			digest <= '0;
		end else begin
			if (rnd.start) begin
				work.flat <= h_init.flat;
				init_q.flat <= h_init.flat;
			end else if (rnd.step) begin
				work <= rounded;
			end
			// holds until the next block finishes
			if (rnd.finish)
				digest <= feed_fwd;
		end
	end

endmodule

//--- msg_schedule.sv
`timescale 1ns/1ps

module msg_schedule (
	input  logic      clk,
	input  logic      rst_n,
	sched_if.datapath sched
);

	import sha256_const_pkg::*;

	word_t win [BLOCK_WORDS];
	word_t next_word;
	word_t shift_word;
	logic  shift_en;

	// sigma0: ror 7, ror 18, shr 3
	function automatic word_t small_sigma0(input word_t x);
		word_t r7;
		word_t r18;
		r7 = {x[6:0], x[31:7]};
		r18 = {x[17:0], x[31:18]};
		return r7 ^ r18 ^ (x >> 3);
	endfunction

	// sigma1: ror 17, ror 19, shr 10
	function automatic word_t small_sigma1(input word_t x);
		word_t r17;
		word_t r19;
		r17 = {x[16:0], x[31:17]};
		r19 = {x[18:0], x[31:19]};
		return r17 ^ r19 ^ (x >> 10);
	endfunction

	// win[0] is w[t], so the taps 16, 15, 7, 2 back from w[t+16]
	// sit at 0, 1, 9 and 14
	assign next_word = small_sigma1(win[14]) + win[9] + small_sigma0(win[1]) + win[0];

	assign shift_en = sched.load || sched.advance;
	assign shift_word = sched.load ? sched.msg_word : next_word;

	//////////////////////////////////////////////////////////////////////////////
	// sliding window
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BLOCK_WORDS; i++)
				win[i] <= '0;
		end else if (shift_en) begin
			for (int i = 0; i < BLOCK_WORDS - 1; i++)
				win[i] <= win[i + 1];
			win[BLOCK_WORDS - 1] <= shift_word;
		end
	end

	// oldest word serves the current round
	assign sched.w_t = win[0];

endmodule

//--- sha256_ctrl.sv
`timescale 1ns/1ps

module sha256_ctrl (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     msg_valid,
	output logic     rdy,
	output logic     done,
	sched_if.ctrl    sched,
	round_if.ctrl    rnd
);

	import sha256_const_pkg::*;
	import sha256_types_pkg::*;

	phase_e     phase;
	logic [3:0] word_cnt;
	round_idx_t round_cnt;
	logic       accept;
	logic       last_word;
	logic       last_round;

	// ready while waiting for or collecting a block
	assign rdy = (phase == ph_idle) || (phase == ph_load);
	assign accept = rdy && msg_valid;

	assign last_word = (word_cnt == 4'(BLOCK_WORDS - 1));
	assign last_round = (round_cnt == round_idx_t'(ROUNDS - 1));

	// h_init goes in with the first word of a block
	assign rnd.start = accept && (phase == ph_idle);
	assign rnd.step = (phase == ph_run);
	assign rnd.round = round_cnt;
	assign rnd.finish = (phase == ph_finish);

	assign sched.load = accept;
	// the last round has no successor word to bring forward
	assign sched.advance = (phase == ph_run) && !last_round;

	//////////////////////////////////////////////////////////////////////////////
	// phase machine
	//////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_idle;
			word_cnt <= '0;
			round_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= (phase == ph_finish);
			unique case (phase)
				ph_idle: begin
					if (accept) begin
						phase <= ph_load;
						word_cnt <= 4'd1;
					end
				end
				ph_load: begin
					if (accept) begin
						if (last_word) begin
							phase <= ph_run;
							word_cnt <= '0;
							round_cnt <= '0;
						end else begin
							word_cnt <= word_cnt + 4'd1;
						end
					end
				end
				ph_run: begin
					round_cnt <= round_cnt + 6'd1;
					if (last_round)
						phase <= ph_finish;
				end
				ph_finish: begin
					// digest is registered on this edge
					phase <= ph_idle;
				end
				default: phase <= ph_idle;
			endcase
		end
	end

endmodule

//--- sha256_if.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////////////
// message schedule control and data
//////////////////////////////////////////////////////////////////////////////

interface sched_if;

	// shift one message word into the window
	logic load;
	sha256_const_pkg::word_t msg_word;
	// shift the window and append the expanded word
	logic advance;
	// word for the round in progress
	sha256_const_pkg::word_t w_t;

	modport ctrl (
		output load,
		output advance
	);

	modport datapath (
		input  load,
		input  advance,
		input  msg_word,
		output w_t
	);

endinterface

//////////////////////////////////////////////////////////////////////////////
// round datapath control
//////////////////////////////////////////////////////////////////////////////

interface round_if;

	logic start;
	logic step;
	sha256_types_pkg::round_idx_t round;
	// feed-forward and digest capture
	logic finish;

	modport ctrl (
		output start,
		output step,
		output round,
		output finish
	);

	modport datapath (
		input start,
		input step,
		input round,
		input finish
	);

endinterface

//--- sha256_types_pkg.sv
package sha256_types_pkg;

	// eight working words, a in the top bits
	typedef struct packed {
		sha256_const_pkg::word_t a;
		sha256_const_pkg::word_t b;
		sha256_const_pkg::word_t c;
		sha256_const_pkg::word_t d;
		sha256_const_pkg::word_t e;
		sha256_const_pkg::word_t f;
		sha256_const_pkg::word_t g;
		sha256_const_pkg::word_t h;
	} hash_words_t;

	// flat view for the ports, word view for the rounds
	typedef union packed {
		logic [255:0] flat;
		hash_words_t  w;
	} hash_state_u;

	// control phases
	typedef enum logic [1:0] {
		ph_idle   = 2'd0,
		ph_load   = 2'd1,
		ph_run    = 2'd2,
		ph_finish = 2'd3
	} phase_e;

	// round number 0..63
	typedef logic [5:0] round_idx_t;

endpackage

//--- sha256_const_pkg.sv
package sha256_const_pkg;

	// one sha-256 word
	typedef logic [31:0] word_t;

	// message words per block
	localparam int BLOCK_WORDS = 16;

	// rounds per compression
	localparam int ROUNDS = 64;

	// round constants, first 32 bits of the fractional parts of the
	// cube roots of the first 64 primes
	localparam word_t ROUND_K [ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

endpackage
